/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_top
FLIST    := all.f
OBJ      := obj_dir
LOG      := sim.log
PASS_MSG := *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

sim: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

/* all.f */
+incdir+.
fd1094_cpu_pkg.sv
fd1094_key_pkg.sv
key_mem_if.sv
fd1094_key_arb.sv
fd1094_key_loader.sv
fd1094_decrypt.sv
fd1094_state_ctrl.sv
fd1094_top.sv
tb_checker.sv
tb_top.sv

/* fd1094_config.svh */
// FD1094 decryption unit configuration
// bus and key table widths, fixed by the 68000 bus
`ifndef FD1094_CONFIG_SVH
`define FD1094_CONFIG_SVH

// word address, bits 23:1 of the cpu bus
`define FD_ADDR_W     23

// cpu data bus
`define FD_DATA_W     16

// key table index, taken from address bits 12:1
`define FD_KEY_IDX_W  12

// key table entries, one byte each
`define FD_KEY_DEPTH  4096

`endif

/* fd1094_cpu_pkg.sv */
// FD1094 cpu side types
// bus word and address types, opcodes watched in the decrypted stream
`include "fd1094_config.svh"

package fd1094_cpu_pkg;

    // word address, numbered as the cpu pins a23..a1
    typedef logic [`FD_ADDR_W:1] cpu_addr_t;

    // one bus word
    typedef logic [`FD_DATA_W-1:0] cpu_word_t;

    // cmpi.l #imm: upper byte 0c, size field 2'b10 in bits 7:6
    // compared against opcode bits 15:6
    localparam logic [9:0] op_cmpil_hi = {8'h0c, 2'b10};

    // return from exception
    localparam cpu_word_t op_rte = 16'h4e73;

    // closing word of the state change sequence
    localparam cpu_word_t st_marker = 16'hffff;

endpackage

/* fd1094_decrypt.sv */
// program fetch decryptor
// looks up the key byte for each opcode fetch and mixes it with
// the current state, data reads pass straight through
`include "fd1094_config.svh"

module fd1094_decrypt
    import fd1094_cpu_pkg::*;
    import fd1094_key_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      as_n,       // address strobe
    input  logic      op_n,       // low on program space fetch
    input  cpu_addr_t addr,
    input  cpu_word_t rom_data,   // encrypted word from rom
    input  fd_state_t st,         // from the state controller
    output logic      dtack_n,
    output cpu_word_t dec,        // plain word back to the cpu
    key_mem_if.master mem
);

    dec_phase_e phase;
    key_byte_t  kb;     // key byte for this address
    cpu_word_t  mask;

    // request straight off as_n so the grant lands in cycle 0
    assign mem.req   = (phase == IDLE) && !as_n && !op_n;
    assign mem.we    = 1'b0;    // read only master
    assign mem.idx   = addr[`FD_KEY_IDX_W:1];
    assign mem.wdata = '0;

    assign kb   = mem.rdata;
    assign mask = {kb ^ st, kb};    // high byte also carries the state

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= IDLE;
            dtack_n <= 1'b1;
        end else begin
            case (phase)
                IDLE: begin
                    if (!as_n && op_n) begin
                        dtack_n <= 1'b0;    // data read, ack in cycle 1
                        phase   <= ACK;
                    end else if (!as_n && mem.gnt) begin
                        phase <= KEY;       // key byte next cycle
                    end
                end
                KEY: begin
                    if (as_n) begin
                        phase <= IDLE;      // cycle dropped early
                    end else begin
                        dtack_n <= 1'b0;    // ack in cycle 2
                        phase   <= ACK;
                    end
                end
                ACK: begin
                    if (as_n) begin
                        dtack_n <= 1'b1;
                        phase   <= IDLE;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    // output word, held through the ack
    always_ff @(posedge clk) begin
        if (phase == IDLE && !as_n && op_n)
            dec <= rom_data;
        else if (phase == KEY)
            dec <= rom_data ^ mask;
    end

    // ack only ever starts inside a bus cycle
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) |-> !as_n);

endmodule

/* fd1094_key_arb.sv */
// key table ram with a fixed priority arbiter
// the decryptor always wins, the loader gets idle cycles only
`include "fd1094_config.svh"

module fd1094_key_arb
    import fd1094_key_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    key_mem_if.memory dec_port,
    key_mem_if.memory load_port
);

    key_byte_t  ram [`FD_KEY_DEPTH];
    key_byte_t  rd_q;           // ram read register
    arb_owner_e owner;          // last grant, steers rd_q
    logic       any_gnt;
    logic       sel_we;
    key_idx_t   sel_idx;
    key_byte_t  sel_wdata;

    // decryptor first, loader only when it is quiet
    assign dec_port.gnt  = dec_port.req;
    assign load_port.gnt = load_port.req && !dec_port.req;
    assign any_gnt       = dec_port.gnt || load_port.gnt;

    // single port, so mux the granted master onto it
    always_comb begin
        if (dec_port.gnt) begin
            sel_we    = dec_port.we;
            sel_idx   = dec_port.idx;
            sel_wdata = dec_port.wdata;
        end else begin
            sel_we    = load_port.we;
            sel_idx   = load_port.idx;
            sel_wdata = load_port.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (any_gnt && sel_we)
            ram[sel_idx] <= sel_wdata;
        else if (any_gnt)
            rd_q <= ram[sel_idx];   // read lands next cycle
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner <= NONE;
        end else begin
            if (dec_port.gnt)
                owner <= DEC;
            else if (load_port.gnt)
                owner <= LOAD;
            else
                owner <= NONE;
        end
    end

    // only the owner sees the read byte
    assign dec_port.rdata  = (owner == DEC)  ? rd_q : '0;
    assign load_port.rdata = (owner == LOAD) ? rd_q : '0;

    // the two peers never share a cycle on the ram
    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(dec_port.gnt && load_port.gnt));

endmodule

/* fd1094_key_loader.sv */
// host key writer
// keeps one key table write pending until the arbiter takes it
module fd1094_key_loader
    import fd1094_key_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      key_we,     // host strobe
    input  key_idx_t  key_addr,
    input  key_byte_t key_data,
    output logic      key_busy,
    key_mem_if.master mem
);

    logic      pend;       // write waiting for the ram
    key_idx_t  idx_q;
    key_byte_t data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend <= 1'b0;
        end else begin
            if (key_we && !pend)
                pend <= 1'b1;       // busy from next cycle
            else if (mem.gnt)
                pend <= 1'b0;       // drops the cycle after the grant
        end
    end

    // host payload, latched with the strobe
    always_ff @(posedge clk) begin
        if (key_we && !pend) begin
            idx_q  <= key_addr;
            data_q <= key_data;
        end
    end

    assign key_busy  = pend;
    assign mem.req   = pend;    // stalls while the decryptor fetches
    assign mem.we    = 1'b1;    // loader only ever writes
    assign mem.idx   = idx_q;
    assign mem.wdata = data_q;

    // host must wait for key_busy to clear
    a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
        key_we |-> !key_busy);

endmodule

/* fd1094_key_pkg.sv */
// FD1094 key side types
// key table entries, decryption state and the small state machine enums
`include "fd1094_config.svh"

package fd1094_key_pkg;

    typedef logic [7:0] key_byte_t;                // one key table entry
    typedef logic [`FD_KEY_IDX_W-1:0] key_idx_t;   // key table index
    typedef logic [7:0] fd_state_t;                // running decryption state

    // who got the key ram last cycle
    typedef enum logic [1:0] {
        NONE,   // nobody, ram idle
        DEC,    // decryptor read
        LOAD    // host loader write
    } arb_owner_e;

    // decryptor fetch phases
    typedef enum logic [1:0] {
        IDLE,   // waiting for as_n
        KEY,    // key byte on rdata
        ACK     // dtack_n held low
    } dec_phase_e;

endpackage

/* fd1094_state_ctrl.sv */
// decryption state tracker
// follows the decrypted opcode stream for cmpi.l / code / ffff
// and for rte and interrupt acknowledge
module fd1094_state_ctrl
    import fd1094_cpu_pkg::*;
    import fd1094_key_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      inta_n,     // interrupt acknowledge
    input  logic      op_n,
    input  cpu_addr_t addr,
    input  cpu_word_t dec,
    input  key_byte_t irq_key,
    input  logic      dtack_n,
    output fd_state_t st
);

    fd_state_t state;
    logic      irq_mode;
    logic [1:0] seq;        // one hot step of the change sequence
    cpu_word_t code;        // captured code word
    logic [2:1] last_addr;
    logic       prog_ack;   // program word on the bus
    logic       new_word;
    logic       step;

    assign prog_ack = !op_n && !dtack_n;
    assign new_word = addr[2:1] != last_addr;   // next fetch in the stream
    assign step     = prog_ack && new_word && seq != 2'b00;

    assign st = irq_mode ? irq_key : state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= '0;
            irq_mode  <= 1'b0;
            seq       <= 2'b00;
            last_addr <= '0;
        end else begin
            if (prog_ack)
                last_addr <= addr[2:1];
            if (prog_ack && seq == 2'b00) begin
                if (dec[15:6] == op_cmpil_hi)
                    seq <= 2'b01;           // arm, code word follows
                if (dec == op_rte)
                    irq_mode <= 1'b0;
            end
            if (!inta_n)
                irq_mode <= 1'b1;
            if (step) begin
                seq <= seq << 1;            // falls out after the marker
                if (seq[1] && dec == st_marker) begin
                    case (code[9:8])
                        2'd0: state <= code[7:0];
                        2'd1: begin
                            state    <= '0;
                            irq_mode <= 1'b0;
                        end
                        2'd2: irq_mode <= 1'b1;
                        2'd3: irq_mode <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    // code word is the fetch right after cmpi.l
    always_ff @(posedge clk) begin
        if (step && seq[0])
            code <= dec;
    end

endmodule

/* fd1094_top.sv */
// FD1094 decryption unit
// decryptor, host key loader, shared key ram and state tracker
module fd1094_top
    import fd1094_cpu_pkg::*;
    import fd1094_key_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      as_n,
    input  logic      op_n,
    input  logic      inta_n,
    input  cpu_addr_t addr,
    input  cpu_word_t rom_data,
    input  key_byte_t irq_key,    // key used in interrupt mode
    input  logic      key_we,
    input  key_idx_t  key_addr,
    input  key_byte_t key_data,
    output logic      key_busy,
    output logic      dtack_n,
    output cpu_word_t dec
);

    fd_state_t st;

    key_mem_if dec_mem ();
    key_mem_if load_mem ();

    fd1094_key_arb u_arb (
        .clk       (clk),
        .rst       (rst),
        .dec_port  (dec_mem),
        .load_port (load_mem)
    );

    fd1094_key_loader u_loader (
        .clk      (clk),
        .rst      (rst),
        .key_we   (key_we),
        .key_addr (key_addr),
        .key_data (key_data),
        .key_busy (key_busy),
        .mem      (load_mem)
    );

    fd1094_decrypt u_dec (
        .clk      (clk),
        .rst      (rst),
        .as_n     (as_n),
        .op_n     (op_n),
        .addr     (addr),
        .rom_data (rom_data),
        .st       (st),
        .dtack_n  (dtack_n),
        .dec      (dec),
        .mem      (dec_mem)
    );

    fd1094_state_ctrl u_st (
        .clk     (clk),
        .rst     (rst),
        .inta_n  (inta_n),
        .op_n    (op_n),
        .addr    (addr),
        .dec     (dec),
        .irq_key (irq_key),
        .dtack_n (dtack_n),
        .st      (st)
    );

endmodule

/* key_mem_if.sv */
// key table request channel
// one master per peer, the arbiter sits on the memory side
interface key_mem_if import fd1094_key_pkg::*; ();

    logic      req;     // held until gnt
    logic      gnt;     // single cycle pulse
    logic      we;      // write when set, read otherwise
    key_idx_t  idx;     // table entry
    key_byte_t wdata;   // write byte
    key_byte_t rdata;   // valid the cycle after a read grant

    // peers requesting access
    modport master (
        output req,
        output we,
        output idx,
        output wdata,
        input  gnt,
        input  rdata
    );

    // arbiter and ram
    modport memory (
        input  req,
        input  we,
        input  idx,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

/* tb_checker.sv */
// FD1094 testbench checker
// keeps a model of keys, state and interrupt mode, and checks every ack
`include "fd1094_config.svh"

module tb_checker
    import fd1094_cpu_pkg::*;
    import fd1094_key_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      as_n,
    input  logic      op_n,
    input  logic      inta_n,
    input  cpu_addr_t addr,
    input  cpu_word_t rom_data,
    input  key_byte_t irq_key,
    input  logic      key_we,
    input  key_idx_t  key_addr,
    input  key_byte_t key_data,
    input  logic      key_busy,
    input  logic      dtack_n,
    input  cpu_word_t dec,
    input  int        test_id,
    input  logic      done,
    output int        checks,
    output int        errors
);
    timeunit 1ns;
    timeprecision 100ps;

    key_byte_t key_model [`FD_KEY_DEPTH];   // what the host has written
    fd_state_t state_model;
    logic      irq_mode;
    int        seq;                         // 0 idle, 1 armed, 2 code seen
    cpu_word_t code_model;
    logic      dtack_q;
    logic      as_q;
    logic      key_acc_q;                   // host strobe seen last cycle
    int        cyc;
    int        as_cyc;                      // cycle where as_n was first seen low
    int        cur_test;
    int        t_checks;
    int        t_errs;
    logic      reported;

    // expected word on dec for one bus cycle
    function automatic cpu_word_t expect_dec(input cpu_addr_t a, input cpu_word_t r,
                                             input logic data_rd);
        key_byte_t kb;
        fd_state_t s;
        if (data_rd)
            return r;                       // data space untouched
        kb = key_model[a[12:1]];
        s  = irq_mode ? irq_key : state_model;
        return r ^ {kb ^ s, kb};
    endfunction

    // step the model on one plain program word
    function automatic void advance_model(input cpu_word_t w);
        if (seq == 0) begin
            if (w[15:6] == op_cmpil_hi)
                seq = 1;
            else if (w == op_rte)
                irq_mode = 1'b0;
        end else if (seq == 1) begin
            code_model = w;                 // code word follows cmpi.l
            seq = 2;
        end else begin
            seq = 0;
            if (w == st_marker) begin
                case (code_model[9:8])
                    2'd0: state_model = code_model[7:0];
                    2'd1: begin
                        state_model = '0;
                        irq_mode = 1'b0;
                    end
                    2'd2: irq_mode = 1'b1;
                    default: irq_mode = 1'b0;
                endcase
            end
        end
    endfunction

    function automatic void report_test();
        $display("test %0d done: %0d checks, %0d errors", cur_test, t_checks, t_errs);
    endfunction

    always @(posedge clk or posedge rst) begin
        cpu_word_t exp;
        if (rst) begin
            state_model = '0;
            irq_mode    = 1'b0;
            seq         = 0;
            dtack_q     = 1'b1;
            as_q        = 1'b1;
            key_acc_q   = 1'b0;
            cyc         = 0;
            as_cyc      = 0;
            cur_test    = 0;
            t_checks    = 0;
            t_errs      = 0;
            checks      = 0;
            errors      = 0;
            reported    = 1'b0;
        end else begin
            cyc = cyc + 1;
            if (as_q && !as_n)
                as_cyc = cyc;               // start of a bus cycle
            if (test_id != cur_test) begin
                if (cur_test != 0)
                    report_test();
                cur_test = test_id;
                t_checks = 0;
                t_errs   = 0;
            end
            // busy must follow a taken strobe by one cycle
            if (key_acc_q) begin
                t_checks++;
                checks++;
                if (!key_busy) begin
                    $display("[ERROR] %0t key_busy low in the cycle after a key write",
                             $time);
                    t_errs++;
                    errors++;
                end
            end
            if (key_we)
                key_model[key_addr] = key_data;
            if (dtack_q && !dtack_n) begin
                exp = expect_dec(addr, rom_data, op_n);
                t_checks++;
                checks++;
                if (dec !== exp) begin
                    $display("[ERROR] %0t dec %h, expected %h, addr %h", $time, dec, exp,
                             addr);
                    t_errs++;
                    errors++;
                end
                if (op_n && (cyc - as_cyc != 1)) begin
                    $display("[ERROR] %0t data ack after %0d cycles, expected 1", $time,
                             cyc - as_cyc);
                    t_errs++;
                    errors++;
                end
                if (!op_n)
                    advance_model(exp);     // exp is the plain word
            end
            if (!inta_n)
                irq_mode = 1'b1;            // acknowledge wins over rte
            if (done && !reported) begin
                report_test();
                $display("total: %0d checks, %0d errors", checks, errors);
                reported = 1'b1;
            end
            dtack_q   = dtack_n;
            as_q      = as_n;
            key_acc_q = key_we;
        end
    end

endmodule

/* tb_top.sv */
// FD1094 testbench top
// clock, reset, host key loading, rom model and cpu bus cycles
`include "fd1094_config.svh"

module tb_top
    import fd1094_cpu_pkg::*;
    import fd1094_key_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic      clk, rst, as_n, op_n, inta_n, key_we, key_busy, dtack_n, done;
    cpu_addr_t addr;
    cpu_word_t rom_data, dec;
    key_byte_t irq_key, key_data;
    key_idx_t  key_addr;
    key_idx_t  late_idx [16];   // keys written under contention
    int        seed = 32'hff4705ad;
    int        test_id, checks, errors;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    fd1094_top u_dut (.*);
    tb_checker u_chk (.*);

    initial begin
        #2ms;
        $display("simulation ran too long, stopped by the watchdog");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // random program word, never cmpi.l or rte
    function automatic cpu_word_t plain_word();
        logic [31:0] r;
        cpu_word_t   w;
        r = rnd();
        w = r[15:0];
        if (w[15:6] == op_cmpil_hi || w == op_rte)
            w[15] = ~w[15];
        return w;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic wait_key_idle();
        int n = 0;
        @(negedge clk);
        while (key_busy) begin
            n++;
            if (n > 200)
                stop_on_timeout("key_busy to fall");
            @(negedge clk);
        end
    endtask

    task automatic write_key(input key_idx_t idx, input key_byte_t data);
        wait_key_idle();
        @(posedge clk);
        key_we   <= 1'b1;
        key_addr <= idx;
        key_data <= data;
        @(posedge clk);
        key_we   <= 1'b0;
    endtask

    // one bus cycle, program words are encrypted with the model state
    task automatic fetch(input cpu_addr_t a, input cpu_word_t plain, input logic data_rd);
        key_byte_t kb;
        fd_state_t s;
        int        n = 0;
        @(negedge clk);                 // model settles on the rising edge
        kb = u_chk.key_model[a[12:1]];
        s  = u_chk.irq_mode ? irq_key : u_chk.state_model;
        @(posedge clk);
        as_n     <= 1'b0;
        op_n     <= data_rd;
        addr     <= a;
        rom_data <= data_rd ? plain : plain ^ {kb ^ s, kb};   // xor undoes itself
        @(negedge clk);
        while (dtack_n) begin
            n++;
            if (n > 20)
                stop_on_timeout("dtack_n to fall");
            @(negedge clk);
        end
        @(posedge clk);
        as_n <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!dtack_n) begin
            n++;
            if (n > 20)
                stop_on_timeout("dtack_n to rise");
            @(negedge clk);
        end
    endtask

    task automatic random_fetches(input int count, input logic data_rd);
        logic [31:0] r;
        repeat (count) begin
            r = rnd();
            fetch(r[22:0], plain_word(), data_rd);
        end
    endtask

    // cmpi.l, code word, ffff at consecutive words
    task automatic state_change(input cpu_addr_t a, input cpu_word_t code);
        fetch(a, 16'h0c80, 1'b0);
        fetch(a + 23'd1, code, 1'b0);
        fetch(a + 23'd2, st_marker, 1'b0);
    endtask

    task automatic inta_pulse();
        @(posedge clk);
        inta_n <= 1'b0;
        @(posedge clk);
        inta_n <= 1'b1;
    endtask

    initial begin
        logic [31:0] r;
        cpu_addr_t   a;
        rst = 1'b1;
        as_n = 1'b1;
        op_n = 1'b1;
        inta_n = 1'b1;
        addr = '0;
        rom_data = '0;
        irq_key = 8'h3c;
        key_we = 1'b0;
        key_addr = '0;
        key_data = '0;
        test_id = 0;
        done = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_id = 1;                    // full key table, state 0
        for (int i = 0; i < `FD_KEY_DEPTH; i++) begin
            r = rnd();
            write_key(key_idx_t'(i), r[7:0]);
        end
        random_fetches(20, 1'b0);

        test_id = 2;                    // data space
        random_fetches(20, 1'b1);

        test_id = 3;
        state_change(23'h000100, 16'h00a7);
        random_fetches(10, 1'b0);

        test_id = 4;                    // interrupt mode in and out
        inta_pulse();
        random_fetches(5, 1'b0);
        fetch(23'h000200, op_rte, 1'b0);
        random_fetches(5, 1'b0);
        state_change(23'h000300, 16'h0200);
        random_fetches(5, 1'b0);
        state_change(23'h000310, 16'h0300);
        random_fetches(5, 1'b0);
        state_change(23'h000320, 16'h0100);
        random_fetches(5, 1'b0);

        test_id = 5;                    // writes to the upper half while fetching the lower
        fork
            begin
                repeat (40) begin
                    r = rnd();
                    a = r[22:0];
                    a[12] = 1'b0;
                    fetch(a, plain_word(), 1'b0);
                end
            end
            begin
                for (int j = 0; j < 16; j++) begin
                    r = rnd();
                    late_idx[j] = key_idx_t'(2048 + j * 37);
                    write_key(late_idx[j], r[7:0]);
                end
            end
        join
        wait_key_idle();
        for (int j = 0; j < 16; j++) begin
            r = rnd();
            a = r[22:0];
            a[12:1] = late_idx[j];
            fetch(a, plain_word(), 1'b0);
        end

        done = 1'b1;
        repeat (3) @(posedge clk);
        if (errors == 0 && checks > 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
